/* vec_pkg.sv */
//*********************************************************************
// Shared definitions for the packed-SIMD integer unit: widths, element
// sizes, opcodes, lane vectors, control word layout and register map.
//*********************************************************************

package vec_pkg;

    localparam int BYTE_WIDTH = 8;
    localparam int DATA_WIDTH = 64;
    localparam int NUM_BYTES  = DATA_WIDTH / BYTE_WIDTH;
    localparam int NUM_OSIZES = 4;

    typedef enum logic [1:0] {SEW_8, SEW_16, SEW_32, SEW_64} sew_t;
    typedef enum logic [1:0] {OP_ADD, OP_SUB, OP_NEG, OP_ABS} alu_op_t;

    // One-hot element size, bit n means 8*2^n bit elements
    typedef logic [NUM_OSIZES-1:0] osize_vector_t;

    // Per-byte lane vectors
    typedef logic [NUM_BYTES-1:0] carry_t;
    typedef logic [NUM_BYTES-1:0] merge_t;
    typedef logic [NUM_BYTES-1:0] complement_t;

    typedef logic [NUM_BYTES-1:0][BYTE_WIDTH-1:0] vec_data_t;

    typedef struct packed {
        logic [26:0] reserved;
        sew_t        sew;
        alu_op_t     op;
        logic        go;
    } ctrl_fields_t;

    typedef union packed {
        logic [31:0]  raw;
        ctrl_fields_t fields;
    } ctrl_word_u;

    // Register map, byte offsets decoded in the low address bits
    localparam int REG_ADR_BITS = 5;
    localparam logic [REG_ADR_BITS-1:0] REG_CTRL   = 5'h00;
    localparam logic [REG_ADR_BITS-1:0] REG_STATUS = 5'h04;
    localparam logic [REG_ADR_BITS-1:0] REG_A_LO   = 5'h08;
    localparam logic [REG_ADR_BITS-1:0] REG_A_HI   = 5'h0C;
    localparam logic [REG_ADR_BITS-1:0] REG_B_LO   = 5'h10;
    localparam logic [REG_ADR_BITS-1:0] REG_B_HI   = 5'h14;
    localparam logic [REG_ADR_BITS-1:0] REG_R_LO   = 5'h18;
    localparam logic [REG_ADR_BITS-1:0] REG_R_HI   = 5'h1C;

    // Copies the bit at each element's lowest byte over the whole element
    function automatic complement_t extend_mask(complement_t mask, osize_vector_t osize_vector);
        complement_t ext;
        int          span;
        ext = '0;
        for (int s = 0; s < NUM_OSIZES; s++) begin
            span = 1 << s;
            for (int i = 0; i < NUM_BYTES; i++) begin
                if (osize_vector[s] && mask[i - (i % span)]) begin
                    ext[i] = 1'b1;
                end
            end
        end
        return ext;
    endfunction

endpackage

/* vec_op_if.sv */
//*********************************************************************
// One vector operation travelling from the register block to the ALU,
// and its result coming back two cycles later.
//*********************************************************************
`timescale 1ns/10ps

interface vec_op_if
    import vec_pkg::*;
();

    // Request side
    logic      op_valid;
    vec_data_t a;
    vec_data_t b;
    alu_op_t   op;
    sew_t      sew;

    // Response side
    logic      res_valid;
    vec_data_t result;

    modport csr (
        output op_valid, a, b, op, sew,
        input  res_valid, result
    );

    modport alu (
        input  op_valid, a, b, op, sew,
        output res_valid, result
    );

endinterface

/* vec_lane_ctrl.sv */
//*********************************************************************
// Lane control for the SIMD datapath. Turns SEW and the opcode into the
// size vector, carry merge vector and per-element complement masks.
//*********************************************************************
`timescale 1ns/10ps

module vec_lane_ctrl
    import vec_pkg::*;
(
    input  sew_t          sew,
    input  alu_op_t       op,
    input  vec_data_t     signs,
    output osize_vector_t osize_vector,
    output merge_t        merge,
    output complement_t   sub_mask,
    output complement_t   neg_mask
);

    logic [3:0]  elem_bytes;
    logic [2:0]  offs_mask;
    complement_t elem_low;
    complement_t elem_sign;

    assign osize_vector = osize_vector_t'(1) << sew;
    assign elem_bytes   = 4'd1 << sew;
    assign offs_mask    = 3'(elem_bytes - 4'd1);

    always_comb begin
        for (int i = 0; i < NUM_BYTES; i++) begin
            elem_low[i] = (3'(i) & offs_mask) == 3'd0;
            // Chain breaks where the next byte opens a new element
            merge[i]    = (3'(i + 1) & offs_mask) != 3'd0;
        end
    end

    // Sign of the owning element, pulled down from its top byte
    always_comb begin
        elem_sign[NUM_BYTES-1] = signs[NUM_BYTES-1][BYTE_WIDTH-1];
        for (int i = NUM_BYTES - 2; i >= 0; i--) begin
            elem_sign[i] = merge[i] ? elem_sign[i+1] : signs[i][BYTE_WIDTH-1];
        end
    end

    assign sub_mask = (op == OP_SUB) ? elem_low : '0;

    always_comb begin
        case (op)
            OP_NEG:  neg_mask = elem_low;
            OP_ABS:  neg_mask = elem_low & elem_sign;
            default: neg_mask = '0;
        endcase
    end

endmodule

/* vec_simd_adder.sv */
//*********************************************************************
// Segmented byte-lane adder. Adds or subtracts per element, with the
// carry chain cut wherever the merge vector is clear.
//*********************************************************************
`timescale 1ns/10ps

module vec_simd_adder
    import vec_pkg::*;
(
    input  vec_data_t     a,
    input  vec_data_t     b,
    input  complement_t   sub_mask,
    input  merge_t        merge,
    input  osize_vector_t osize_vector,
    output vec_data_t     sum
);

    complement_t sub_ext;
    vec_data_t   b_sel;
    carry_t      carry_in;
    carry_t      carry_out;

    // Subtraction inverts b over the whole element
    assign sub_ext = extend_mask(sub_mask, osize_vector);

    generate
        for (genvar i = 0; i < NUM_BYTES; i++) begin : gen_byte
            assign b_sel[i] = b[i] ^ {BYTE_WIDTH{sub_ext[i]}};

            if (i == 0) begin : gen_first
                assign carry_in[i] = sub_mask[i];
            end else begin : gen_chain
                // The +1 of a subtract enters at the element's lowest byte
                assign carry_in[i] = sub_mask[i] | (carry_out[i-1] & merge[i-1]);
            end

            assign {carry_out[i], sum[i]} = {1'b0, a[i]} + {1'b0, b_sel[i]}
                                          + {{BYTE_WIDTH{1'b0}}, carry_in[i]};
        end
    endgenerate

endmodule

/* vec_twos_comp_sel.sv */
//*********************************************************************
// Conditional two's-complement negation per element. A set complement
// bit at an element's lowest byte inverts that element and adds one;
// other elements pass through unchanged.
//*********************************************************************
`timescale 1ns/10ps

module vec_twos_comp_sel
    import vec_pkg::*;
(
    input  vec_data_t     data,
    input  complement_t   complement,
    input  osize_vector_t osize_vector,
    input  merge_t        merge,
    output vec_data_t     result
);

    complement_t complement_ext;
    vec_data_t   data_xor;
    carry_t      carry_in;
    carry_t      carry_out;

    assign complement_ext = extend_mask(complement, osize_vector);

    generate
        for (genvar i = 0; i < NUM_BYTES; i++) begin : gen_byte
            // Ones' complement of the selected bytes
            assign data_xor[i] = data[i] ^ {BYTE_WIDTH{complement_ext[i]}};

            if (i == 0) begin : gen_first
                assign carry_in[i] = complement[i];
            end else begin : gen_chain
                // Merge keeps the +1 ripple inside one element
                assign carry_in[i] = complement[i] | (carry_out[i-1] & merge[i-1]);
            end

            assign {carry_out[i], result[i]} = {1'b0, data_xor[i]}
                                             + {{BYTE_WIDTH{1'b0}}, carry_in[i]};
        end
    endgenerate

endmodule

/* vec_simd_alu.sv */
//*********************************************************************
// Two-stage SIMD datapath. Stage 1 adds or subtracts per element,
// stage 2 negates the elements selected by NEG or ABS.
//*********************************************************************
`timescale 1ns/10ps

module vec_simd_alu
    import vec_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    vec_op_if.alu op_if
);

    osize_vector_t s1_osize;
    osize_vector_t s2_osize;
    merge_t        s1_merge;
    merge_t        s2_merge;
    complement_t   sub_mask;
    complement_t   neg_mask;
    vec_data_t     b_sel;
    vec_data_t     sum;
    vec_data_t     neg_result;

    logic          s1_valid;
    vec_data_t     s1_sum;
    alu_op_t       s1_op;
    sew_t          s1_sew;

    // NEG and ABS work on a alone
    assign b_sel = (op_if.op == OP_NEG || op_if.op == OP_ABS) ? '0 : op_if.b;

    vec_lane_ctrl lane_s1_i (
        .sew          (op_if.sew),
        .op           (op_if.op),
        .signs        (op_if.a),
        .osize_vector (s1_osize),
        .merge        (s1_merge),
        .sub_mask     (sub_mask),
        .neg_mask     ()
    );

    vec_simd_adder adder_i (
        .a            (op_if.a),
        .b            (b_sel),
        .sub_mask     (sub_mask),
        .merge        (s1_merge),
        .osize_vector (s1_osize),
        .sum          (sum)
    );

    // Stage 2 takes its signs from the registered sum
    vec_lane_ctrl lane_s2_i (
        .sew          (s1_sew),
        .op           (s1_op),
        .signs        (s1_sum),
        .osize_vector (s2_osize),
        .merge        (s2_merge),
        .sub_mask     (),
        .neg_mask     (neg_mask)
    );

    vec_twos_comp_sel neg_i (
        .data         (s1_sum),
        .complement   (neg_mask),
        .osize_vector (s2_osize),
        .merge        (s2_merge),
        .result       (neg_result)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid        <= 1'b0;
            op_if.res_valid <= 1'b0;
        end else begin
            s1_valid        <= op_if.op_valid;
            op_if.res_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (op_if.op_valid) begin
            s1_sum <= sum;
            s1_op  <= op_if.op;
            s1_sew <= op_if.sew;
        end
        if (s1_valid) begin
            op_if.result <= neg_result;
        end
    end

endmodule

/* vec_csr_wb.sv */
//*********************************************************************
// Wishbone classic register block. Holds operands, control word,
// done flag and result; a CTRL write with go set starts an operation.
//*********************************************************************
`timescale 1ns/10ps

module vec_csr_wb
    import vec_pkg::*;
#(
    parameter int ADR_WIDTH = 5
)
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [ADR_WIDTH-1:0] wb_adr,
    input  logic [31:0]          wb_wdata,
    output logic [31:0]          wb_rdata,
    output logic                 wb_ack,
    vec_op_if.csr                op_if
);

    logic [REG_ADR_BITS-1:0] reg_adr;
    logic                    req;
    logic                    wr_en;
    ctrl_word_u              ctrl;
    ctrl_word_u              wdata_ctrl;
    ctrl_word_u              ctrl_rd;
    logic [31:0]             a_lo;
    logic [31:0]             a_hi;
    logic [31:0]             b_lo;
    logic [31:0]             b_hi;
    logic [31:0]             r_lo;
    logic [31:0]             r_hi;
    logic                    done;
    logic [31:0]             rd_mux;

    assign reg_adr    = wb_adr[REG_ADR_BITS-1:0];
    // New request, ack answers one cycle later without wait states
    assign req        = wb_cyc & wb_stb & ~wb_ack;
    // Writes commit in the ack cycle
    assign wr_en      = wb_ack & wb_cyc & wb_stb & wb_we;
    assign wdata_ctrl.raw = wb_wdata;

    assign op_if.a   = {a_hi, a_lo};
    assign op_if.b   = {b_hi, b_lo};
    assign op_if.op  = ctrl.fields.op;
    assign op_if.sew = ctrl.fields.sew;

    // go is a strobe and always reads back as zero
    always_comb begin
        ctrl_rd.raw        = '0;
        ctrl_rd.fields.op  = ctrl.fields.op;
        ctrl_rd.fields.sew = ctrl.fields.sew;
        case (reg_adr)
            REG_CTRL:   rd_mux = ctrl_rd.raw;
            REG_STATUS: rd_mux = {31'b0, done};
            REG_A_LO:   rd_mux = a_lo;
            REG_A_HI:   rd_mux = a_hi;
            REG_B_LO:   rd_mux = b_lo;
            REG_B_HI:   rd_mux = b_hi;
            REG_R_LO:   rd_mux = r_lo;
            REG_R_HI:   rd_mux = r_hi;
            default:    rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack         <= 1'b0;
            wb_rdata       <= '0;
            op_if.op_valid <= 1'b0;
            ctrl.raw       <= '0;
            a_lo           <= '0;
            a_hi           <= '0;
            b_lo           <= '0;
            b_hi           <= '0;
            r_lo           <= '0;
            r_hi           <= '0;
            done           <= 1'b0;
        end else begin
            wb_ack         <= req;
            op_if.op_valid <= 1'b0;
            if (req) begin
                wb_rdata <= rd_mux;
            end
            if (wr_en) begin
                case (reg_adr)
                    REG_CTRL: begin
                        ctrl.raw       <= wb_wdata;
                        op_if.op_valid <= wdata_ctrl.fields.go;
                    end
                    REG_A_LO: a_lo <= wb_wdata;
                    REG_A_HI: a_hi <= wb_wdata;
                    REG_B_LO: b_lo <= wb_wdata;
                    REG_B_HI: b_hi <= wb_wdata;
                    default:  ;
                endcase
            end
            // A new start wins over a result landing in the same cycle
            if (op_if.op_valid) begin
                done <= 1'b0;
            end else if (op_if.res_valid) begin
                done <= 1'b1;
            end
            if (op_if.res_valid) begin
                r_lo <= op_if.result[NUM_BYTES/2-1:0];
                r_hi <= op_if.result[NUM_BYTES-1:NUM_BYTES/2];
            end
        end
    end

endmodule

/* vec_simd_top.sv */
//*********************************************************************
// Top level of the packed-SIMD unit. Wishbone register block beside
// the two-stage ALU, joined by one operation interface.
//*********************************************************************
`timescale 1ns/10ps

module vec_simd_top #(
    parameter int ADR_WIDTH = 5
)
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [ADR_WIDTH-1:0] wb_adr,
    input  logic [31:0]          wb_wdata,
    output logic [31:0]          wb_rdata,
    output logic                 wb_ack
);

    vec_op_if op_if ();

    vec_csr_wb #(
        .ADR_WIDTH (ADR_WIDTH)
    ) csr_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack),
        .op_if    (op_if.csr)
    );

    vec_simd_alu alu_i (
        .clk    (clk),
        .arst_n (arst_n),
        .op_if  (op_if.alu)
    );

endmodule

/* vec_simd_tb_model.svh */
//*********************************************************************
// Testbench helpers for the SIMD unit: reference model, operand LFSR
// and compare tasks. Included inside the testbench module.
//*********************************************************************
`ifndef VEC_SIMD_TB_MODEL_SVH
`define VEC_SIMD_TB_MODEL_SVH

int          check_count = 0;
int          error_count = 0;
logic [15:0] lfsr_state  = 16'd28911;

// 16-bit Galois LFSR, one step per call
function automatic logic [15:0] lfsr_next(logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
endfunction

task automatic random_data(output vec_data_t d);
    logic [63:0] w;
    w = '0;
    for (int i = 0; i < DATA_WIDTH; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        w = {w[62:0], lfsr_state[0]};
    end
    d = w;
endtask

// Expected result, one element at a time modulo 2^SEW
task automatic model_op(input vec_data_t a, input vec_data_t b, input alu_op_t op,
                        input sew_t sew, output vec_data_t r);
    int          ew;
    logic [63:0] mask;
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] er;
    logic [63:0] acc;
    ew   = 8 << sew;
    mask = (64'd1 << ew) - 64'd1;
    acc  = '0;
    for (int e = 0; e < DATA_WIDTH / ew; e++) begin
        ea = (64'(a) >> (e * ew)) & mask;
        eb = (64'(b) >> (e * ew)) & mask;
        case (op)
            OP_ADD:  er = ea + eb;
            OP_SUB:  er = ea - eb;
            OP_NEG:  er = 64'd0 - ea;
            default: er = ea[ew-1] ? 64'd0 - ea : ea;
        endcase
        acc = acc | ((er & mask) << (e * ew));
    end
    r = acc;
endtask

task automatic check_data(input string name, input vec_data_t exp, input vec_data_t act);
    check_count++;
    if (act !== exp) begin
        error_count++;
        $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
    end
endtask

task automatic check_ctrl(input string name, input ctrl_word_u exp, input ctrl_word_u act);
    check_count++;
    if (act.raw !== exp.raw) begin
        error_count++;
        $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp.raw, act.raw);
    end
endtask

task automatic check_status(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (act !== exp) begin
        error_count++;
        $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
    end
endtask

`endif

/* vec_simd_tb.sv */
//*********************************************************************
// Directed testbench for the SIMD unit. Drives the Wishbone ports,
// runs ADD, SUB, NEG and ABS at every SEW and checks against a model.
//*********************************************************************
`timescale 1ns/10ps

module vec_simd_tb
    import vec_pkg::*;
();

    // Operations issued by all tests plus some spare
    localparam int NUM_TESTS   = 48;
    localparam int WATCHDOG_NS = NUM_TESTS * 40 * 100;

    logic        clk;
    logic        arst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [4:0]  wb_adr;
    logic [31:0] wb_wdata;
    logic [31:0] wb_rdata;
    logic        wb_ack;

    `include "vec_simd_tb_model.svh"

    vec_simd_top dut_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack)
    );

    always #50 clk = ~clk;

    // One classic cycle with the ack sampled on the falling edge
    task automatic bus_cycle(input logic we, input logic [4:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        logic acked;
        acked = 1'b0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_wdata <= wdata;
        for (int i = 0; i < 10 && !acked; i++) begin
            @(negedge clk);
            acked = wb_ack;
        end
        rdata = wb_rdata;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        if (!acked) begin
            error_count++;
            $display("No ack from the DUT within 10 cycles at address %h", adr);
        end
    endtask

    task automatic wb_write(input logic [4:0] adr, input logic [31:0] data);
        logic [31:0] ignored;
        bus_cycle(1'b1, adr, data, ignored);
    endtask

    task automatic wb_read(input logic [4:0] adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, 32'd0, data);
    endtask

    task automatic start_op(input alu_op_t op, input sew_t sew);
        ctrl_word_u cw;
        cw.raw        = '0;
        cw.fields.go  = 1'b1;
        cw.fields.op  = op;
        cw.fields.sew = sew;
        wb_write(REG_CTRL, cw.raw);
    endtask

    task automatic wait_done();
        logic [31:0] status;
        status = '0;
        for (int i = 0; i < 20 && !status[0]; i++) begin
            wb_read(REG_STATUS, status);
        end
        if (!status[0]) begin
            error_count++;
            $display("Done flag was not set within 20 status reads");
        end
    endtask

    task automatic load_operands(input vec_data_t a, input vec_data_t b);
        wb_write(REG_A_LO, a[3:0]);
        wb_write(REG_A_HI, a[7:4]);
        wb_write(REG_B_LO, b[3:0]);
        wb_write(REG_B_HI, b[7:4]);
    endtask

    task automatic read_result(output vec_data_t r);
        logic [31:0] lo;
        logic [31:0] hi;
        wb_read(REG_R_LO, lo);
        wb_read(REG_R_HI, hi);
        r = {hi, lo};
    endtask

    task automatic run_op(input alu_op_t op, input sew_t sew, input vec_data_t a,
                          input vec_data_t b);
        vec_data_t expected;
        vec_data_t actual;
        load_operands(a, b);
        start_op(op, sew);
        wait_done();
        read_result(actual);
        model_op(a, b, op, sew, expected);
        check_data($sformatf("R %s SEW %0d", op.name(), 8 << sew), expected, actual);
    endtask

    // Elements step through zero, max positive, minus one and most negative starting at k
    function automatic vec_data_t sign_pattern(sew_t sew, int k);
        int          ew;
        logic [63:0] w;
        logic [63:0] v;
        ew = 8 << sew;
        w  = '0;
        for (int e = 0; e < DATA_WIDTH / ew; e++) begin
            case ((e + k) % 4)
                0:       v = 64'd0;
                1:       v = (64'd1 << (ew - 1)) - 64'd1;
                2:       v = ~64'd0;
                default: v = 64'd1 << (ew - 1);
            endcase
            w = w | ((v & ((64'd1 << ew) - 64'd1)) << (e * ew));
        end
        return w;
    endfunction

    task automatic test_reset_values();
        logic [31:0] data;
        ctrl_word_u  cw;
        vec_data_t   r;
        wb_read(REG_STATUS, data);
        check_status("STATUS after reset", 32'd0, data);
        wb_read(REG_CTRL, data);
        cw.raw = data;
        check_ctrl("CTRL after reset", '0, cw);
        read_result(r);
        check_data("R after reset", '0, r);
    endtask

    task automatic test_add_sub();
        vec_data_t a;
        vec_data_t b;
        for (int s = 0; s < NUM_OSIZES; s++) begin
            random_data(a);
            random_data(b);
            run_op(OP_ADD, sew_t'(s), a, b);
            run_op(OP_SUB, sew_t'(s), a, b);
            // All ones plus one must stop at the lowest element
            run_op(OP_ADD, sew_t'(s), '1, 64'd1);
        end
    endtask

    task automatic test_neg_abs();
        vec_data_t a;
        vec_data_t b;
        for (int s = 0; s < NUM_OSIZES; s++) begin
            // Random b that NEG and ABS must ignore
            random_data(a);
            random_data(b);
            run_op(OP_NEG, sew_t'(s), a, b);
            run_op(OP_NEG, sew_t'(s), sign_pattern(sew_t'(s), 3), b);
            random_data(a);
            run_op(OP_ABS, sew_t'(s), a, b);
            for (int k = 0; k < 4; k++) begin
                run_op(OP_ABS, sew_t'(s), sign_pattern(sew_t'(s), k), b);
            end
        end
    endtask

    task automatic test_ctrl_done();
        ctrl_word_u  expected;
        ctrl_word_u  actual;
        logic [31:0] data;
        vec_data_t   a;
        vec_data_t   b;
        vec_data_t   r;
        vec_data_t   ref_r;
        random_data(a);
        random_data(b);
        load_operands(a, b);
        expected.raw        = '0;
        expected.fields.op  = OP_ABS;
        expected.fields.sew = SEW_32;
        start_op(OP_ABS, SEW_32);
        wb_read(REG_CTRL, data);
        actual.raw = data;
        check_ctrl("CTRL readback", expected, actual);
        wait_done();
        wb_read(REG_STATUS, data);
        check_status("STATUS after result", 32'd1, data);
        start_op(OP_NEG, SEW_16);
        wb_read(REG_STATUS, data);
        check_status("STATUS after new go", 32'd0, data);
        wait_done();
        // Back-to-back starts leave the second result in R
        start_op(OP_ADD, SEW_8);
        start_op(OP_SUB, SEW_64);
        wait_done();
        read_result(r);
        model_op(a, b, OP_SUB, SEW_64, ref_r);
        check_data("R after back-to-back go", ref_r, r);
    endtask

    initial begin
        clk      = 1'b0;
        arst_n   = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_wdata = '0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        test_reset_values();
        test_add_sub();
        test_neg_abs();
        test_ctrl_done();
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the number of tests
    initial begin
        #(WATCHDOG_NS);
        $display("Simulation timed out after %0d ns with %0d errors", WATCHDOG_NS, error_count);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* vec_simd_top.f */
+incdir+.
vec_pkg.sv
vec_op_if.sv
vec_lane_ctrl.sv
vec_simd_adder.sv
vec_twos_comp_sel.sv
vec_simd_alu.sv
vec_csr_wb.sv
vec_simd_top.sv
vec_simd_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the SIMD unit testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --top-module vec_simd_tb -f vec_simd_top.f -o vec_simd_sim \
    && ./obj_dir/vec_simd_sim | tee sim.log \
    || { echo "Build or simulation did not complete"; exit 1; }
grep -q "TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "No result found in sim.log"; exit 1; }
echo "Simulation passed"
